//--- filelist.f
burst_split_pkg.sv
ax_splitter.sv
burst_len_fifo.sv
b_merge.sv
r_last_gen.sv
burst_splitter_top.sv
tb_burst_splitter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the burst splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation finished: FAIL"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_burst_splitter \
  -Mdir obj_dir -o Vtb_burst_splitter
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/Vtb_burst_splitter > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Result: testbench reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

echo "Result: testbench passed"
exit 0

//--- tb_burst_splitter.sv
// Testbench that runs read and write bursts through the splitter against a slave model
`timescale 1ns/1ps
`default_nettype none

module tb_burst_splitter;
  import burst_split_pkg::*;

  localparam int    N_BURSTS   = 40;
  localparam int    N_DIRECTED = 4;
  localparam int    TIMEOUT    = 2000;
  // Slave answers SLVERR inside this window
  localparam addr_t ERR_LO     = 32'h0000_1200;
  localparam addr_t ERR_HI     = 32'h0000_1240;

  integer seed = 26378;
  int     error_count = 0;

  logic   clk_i = 1'b0;
  logic   arst_n_i = 1'b0;

  // Upstream side driven by the master model
  addr_t  s_aw_addr = '0;
  addr_t  s_ar_addr = '0;
  len_t   s_aw_len = '0;
  len_t   s_ar_len = '0;
  size_t  s_aw_size = '0;
  size_t  s_ar_size = '0;
  burst_e s_aw_burst = BURST_INCR;
  burst_e s_ar_burst = BURST_INCR;
  data_t  s_w_data = '0;
  logic [DATA_W/8-1:0] s_w_strb = '0;
  logic   s_aw_valid = 1'b0, s_w_valid = 1'b0, s_w_last = 1'b0, s_ar_valid = 1'b0;
  logic   s_b_ready = 1'b0, s_r_ready = 1'b0;
  logic   s_aw_ready, s_w_ready, s_b_valid, s_ar_ready, s_r_valid, s_r_last;
  resp_e  s_b_resp, s_r_resp;
  data_t  s_r_data;

  // Downstream side driven by the slave model
  logic   m_aw_ready = 1'b0, m_w_ready = 1'b0, m_ar_ready = 1'b0;
  logic   m_b_valid = 1'b0, m_r_valid = 1'b0;
  resp_e  m_b_resp = RESP_OKAY;
  resp_e  m_r_resp = RESP_OKAY;
  data_t  m_r_data = '0;
  addr_t  m_aw_addr, m_ar_addr;
  len_t   m_aw_len, m_ar_len;
  size_t  m_aw_size, m_ar_size;
  burst_e m_aw_burst, m_ar_burst;
  data_t  m_w_data;
  logic [DATA_W/8-1:0] m_w_strb;
  logic   m_aw_valid, m_w_valid, m_w_last, m_b_ready, m_ar_valid, m_r_ready;

  // Burst list per direction with index 0 for reads and 1 for writes
  addr_t  p_addr  [2][N_BURSTS];
  len_t   p_len   [2][N_BURSTS];
  size_t  p_size  [2][N_BURSTS];
  burst_e p_burst [2][N_BURSTS];

  addr_t  exp_ar_q[$], exp_aw_q[$], rd_pend_q[$], aw_pend_q[$];
  size_t  exp_ar_size_q[$], exp_aw_size_q[$];
  burst_e exp_ar_burst_q[$], exp_aw_burst_q[$];
  data_t  exp_r_data_q[$], w_pend_q[$];
  logic [DATA_W/8-1:0] w_strb_pend_q[$];
  resp_e  exp_r_resp_q[$], exp_b_q[$];
  logic   exp_r_last_q[$];

  always #2 clk_i = ~clk_i;

  burst_splitter_top dut (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .s_aw_addr_i (s_aw_addr), .s_aw_len_i (s_aw_len), .s_aw_size_i (s_aw_size),
    .s_aw_burst_i (s_aw_burst), .s_aw_valid_i (s_aw_valid), .s_aw_ready_o (s_aw_ready),
    .s_w_data_i (s_w_data), .s_w_strb_i (s_w_strb), .s_w_last_i (s_w_last),
    .s_w_valid_i (s_w_valid), .s_w_ready_o (s_w_ready),
    .s_b_resp_o (s_b_resp), .s_b_valid_o (s_b_valid), .s_b_ready_i (s_b_ready),
    .s_ar_addr_i (s_ar_addr), .s_ar_len_i (s_ar_len), .s_ar_size_i (s_ar_size),
    .s_ar_burst_i (s_ar_burst), .s_ar_valid_i (s_ar_valid), .s_ar_ready_o (s_ar_ready),
    .s_r_data_o (s_r_data), .s_r_resp_o (s_r_resp), .s_r_last_o (s_r_last),
    .s_r_valid_o (s_r_valid), .s_r_ready_i (s_r_ready),
    .m_aw_addr_o (m_aw_addr), .m_aw_len_o (m_aw_len), .m_aw_size_o (m_aw_size),
    .m_aw_burst_o (m_aw_burst), .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready),
    .m_w_data_o (m_w_data), .m_w_strb_o (m_w_strb), .m_w_last_o (m_w_last),
    .m_w_valid_o (m_w_valid), .m_w_ready_i (m_w_ready),
    .m_b_resp_i (m_b_resp), .m_b_valid_i (m_b_valid), .m_b_ready_o (m_b_ready),
    .m_ar_addr_o (m_ar_addr), .m_ar_len_o (m_ar_len), .m_ar_size_o (m_ar_size),
    .m_ar_burst_o (m_ar_burst), .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_r_data_i (m_r_data), .m_r_resp_i (m_r_resp), .m_r_valid_i (m_r_valid),
    .m_r_ready_o (m_r_ready)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic addr_t beat_addr(addr_t start, size_t size, burst_e burst, int idx);
    if (burst == BURST_FIXED) begin
      return start;
    end
    return start + (addr_t'(idx) << size);
  endfunction

  function automatic data_t ref_data(addr_t a);
    return {a[15:0] ^ 16'hC3A5, a[31:16] ^ ~a[15:0]};
  endfunction

  // W payload differs from R data so a mixup shows
  function automatic data_t wr_data(addr_t a);
    return ref_data(a) ^ 32'h5A5A_0F0F;
  endfunction

  // Strobe pattern taken from the beat address
  function automatic logic [DATA_W/8-1:0] wr_strb(addr_t a);
    return a[DATA_W/8+1:2] ^ {(DATA_W/8){a[6]}};
  endfunction

  function automatic logic in_err_window(addr_t a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  function automatic logic rand_ready();
    integer r;
    r = $random(seed);
    return r[1:0] != 2'b00;
  endfunction

  function automatic logic drained();
    return exp_ar_q.size() == 0 && exp_aw_q.size() == 0 && exp_r_data_q.size() == 0
      && exp_b_q.size() == 0 && rd_pend_q.size() == 0 && aw_pend_q.size() == 0
      && w_pend_q.size() == 0;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic fail_now(string what);
    error_count++;
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failed check");
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_strb(string name, logic [DATA_W/8-1:0] got,
                            logic [DATA_W/8-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_resp(string name, resp_e got, resp_e exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_len(string name, len_t got, len_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_size(string name, size_t got, size_t exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_burst(string name, burst_e got, burst_e exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_last(string name, logic got, logic exp);
    if (got !== exp) begin
      fail_now($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic set_burst(int dir, int i, addr_t a, len_t len, size_t sz, burst_e bt);
    p_addr[dir][i]  = a;
    p_len[dir][i]   = len;
    p_size[dir][i]  = sz;
    p_burst[dir][i] = bt;
  endtask

  task automatic random_burst(int dir, int i);
    integer r;
    size_t  sz;
    addr_t  a;
    r  = $random(seed);
    sz = (r[4:3] == 2'b11) ? size_t'(2) : size_t'(r[4:3]);
    a  = 32'h0000_1000 + addr_t'(r[17:8]);
    a  = a & ~((addr_t'(1) << sz) - addr_t'(1));
    set_burst(dir, i, a, len_t'(r[2:0]), sz, (r[6:5] != 2'b00) ? BURST_INCR : BURST_FIXED);
  endtask

  // Expected beats are queued when a burst is first offered
  task automatic push_expected(int dir, int i);
    int    b;
    addr_t a;
    logic  err;
    err = 1'b0;
    for (b = 0; b <= int'(p_len[dir][i]); b++) begin
      a   = beat_addr(p_addr[dir][i], p_size[dir][i], p_burst[dir][i], b);
      err = err | in_err_window(a);
      if (dir == 0) begin
        exp_ar_q.push_back(a);
        exp_ar_size_q.push_back(p_size[dir][i]);
        exp_ar_burst_q.push_back(p_burst[dir][i]);
        exp_r_data_q.push_back(ref_data(a));
        exp_r_resp_q.push_back(in_err_window(a) ? RESP_SLVERR : RESP_OKAY);
        exp_r_last_q.push_back(b == int'(p_len[dir][i]));
      end else begin
        exp_aw_q.push_back(a);
        exp_aw_size_q.push_back(p_size[dir][i]);
        exp_aw_burst_q.push_back(p_burst[dir][i]);
      end
    end
    if (dir == 1) begin
      exp_b_q.push_back(err ? RESP_SLVERR : RESP_OKAY);
    end
  endtask

  task automatic drive_bursts(int dir);
    int   i;
    int   cnt;
    logic ready;
    for (i = 0; i < N_BURSTS; i++) begin
      push_expected(dir, i);
      if (dir == 0) begin
        s_ar_addr  = p_addr[0][i];
        s_ar_len   = p_len[0][i];
        s_ar_size  = p_size[0][i];
        s_ar_burst = p_burst[0][i];
        s_ar_valid = 1'b1;
      end else begin
        s_aw_addr  = p_addr[1][i];
        s_aw_len   = p_len[1][i];
        s_aw_size  = p_size[1][i];
        s_aw_burst = p_burst[1][i];
        s_aw_valid = 1'b1;
      end
      cnt   = 0;
      ready = 1'b0;
      while (!ready) begin
        @(posedge clk_i);
        ready = (dir == 0) ? s_ar_ready : s_aw_ready;
        cnt++;
        if (cnt > TIMEOUT) begin
          fail_now("Timeout waiting for the address channel to accept a burst");
        end
      end
      #1;
      s_ar_valid = (dir == 0) ? 1'b0 : s_ar_valid;
      s_aw_valid = (dir == 1) ? 1'b0 : s_aw_valid;
      if (!rand_ready()) begin
        @(posedge clk_i);
        #1;
      end
    end
  endtask

  task automatic drive_wdata();
    int    i;
    int    b;
    int    cnt;
    addr_t a;
    for (i = 0; i < N_BURSTS; i++) begin
      for (b = 0; b <= int'(p_len[1][i]); b++) begin
        a         = beat_addr(p_addr[1][i], p_size[1][i], p_burst[1][i], b);
        s_w_data  = wr_data(a);
        s_w_strb  = wr_strb(a);
        s_w_last  = (b == int'(p_len[1][i]));
        s_w_valid = 1'b1;
        cnt = 0;
        do begin
          @(posedge clk_i);
          cnt++;
          if (cnt > TIMEOUT) begin
            fail_now("Timeout waiting for the W channel to accept a beat");
          end
        end while (!s_w_ready);
        #1;
        s_w_valid = 1'b0;
      end
    end
  endtask

  // --------------------------------------------------
  // Downstream slave model
  // --------------------------------------------------
  always @(posedge clk_i) begin
    addr_t a;
    logic  r_take;
    r_take = m_r_valid && m_r_ready;
    if (arst_n_i && m_ar_valid && m_ar_ready) begin
      if (exp_ar_q.size() == 0) begin
        fail_now("Downstream read request arrived with no beat expected");
      end
      check_addr("m_ar_addr_o", m_ar_addr, exp_ar_q.pop_front());
      check_len("m_ar_len_o", m_ar_len, '0);
      check_size("m_ar_size_o", m_ar_size, exp_ar_size_q.pop_front());
      check_burst("m_ar_burst_o", m_ar_burst, exp_ar_burst_q.pop_front());
      rd_pend_q.push_back(m_ar_addr);
    end
    #1;
    m_ar_ready = rand_ready();
    if (r_take || !m_r_valid) begin
      if (rd_pend_q.size() > 0 && rand_ready()) begin
        a         = rd_pend_q.pop_front();
        m_r_data  = ref_data(a);
        m_r_resp  = in_err_window(a) ? RESP_SLVERR : RESP_OKAY;
        m_r_valid = 1'b1;
      end else begin
        m_r_valid = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    addr_t a;
    logic  b_take;
    b_take = m_b_valid && m_b_ready;
    if (arst_n_i && m_aw_valid && m_aw_ready) begin
      if (exp_aw_q.size() == 0) begin
        fail_now("Downstream write request arrived with no beat expected");
      end
      check_addr("m_aw_addr_o", m_aw_addr, exp_aw_q.pop_front());
      check_len("m_aw_len_o", m_aw_len, '0);
      check_size("m_aw_size_o", m_aw_size, exp_aw_size_q.pop_front());
      check_burst("m_aw_burst_o", m_aw_burst, exp_aw_burst_q.pop_front());
      aw_pend_q.push_back(m_aw_addr);
    end
    if (arst_n_i && m_w_valid && m_w_ready) begin
      check_last("m_w_last_o", m_w_last, 1'b1);
      w_pend_q.push_back(m_w_data);
      w_strb_pend_q.push_back(m_w_strb);
    end
    #1;
    m_aw_ready = rand_ready();
    m_w_ready  = rand_ready();
    // One B per address and data pair
    if (b_take || !m_b_valid) begin
      if (aw_pend_q.size() > 0 && w_pend_q.size() > 0 && rand_ready()) begin
        a = aw_pend_q.pop_front();
        check_data("m_w_data_o", w_pend_q.pop_front(), wr_data(a));
        check_strb("m_w_strb_o", w_strb_pend_q.pop_front(), wr_strb(a));
        m_b_resp  = in_err_window(a) ? RESP_SLVERR : RESP_OKAY;
        m_b_valid = 1'b1;
      end else begin
        m_b_valid = 1'b0;
      end
    end
  end

  // Upstream response checker
  always @(posedge clk_i) begin
    if (arst_n_i && s_r_valid && s_r_ready) begin
      if (exp_r_data_q.size() == 0) begin
        fail_now("Upstream read beat arrived with no beat expected");
      end
      check_data("s_r_data_o", s_r_data, exp_r_data_q.pop_front());
      check_resp("s_r_resp_o", s_r_resp, exp_r_resp_q.pop_front());
      check_last("s_r_last_o", s_r_last, exp_r_last_q.pop_front());
    end
    if (arst_n_i && s_b_valid && s_b_ready) begin
      if (exp_b_q.size() == 0) begin
        fail_now("Upstream write response arrived with no burst outstanding");
      end
      check_resp("s_b_resp_o", s_b_resp, exp_b_q.pop_front());
    end
    #1;
    s_r_ready = rand_ready();
    s_b_ready = rand_ready();
  end

  initial begin
    int i;
    int cnt;
    // Directed cases first and random bursts after them
    set_burst(0, 0, 32'h0000_1000, 8'd3, 3'd2, BURST_INCR);
    set_burst(0, 1, 32'h0000_1010, 8'd3, 3'd2, BURST_FIXED);
    set_burst(0, 2, 32'h0000_1020, 8'd0, 3'd2, BURST_INCR);
    set_burst(0, 3, 32'h0000_1203, 8'd7, 3'd0, BURST_INCR);
    set_burst(1, 0, 32'h0000_1030, 8'd0, 3'd2, BURST_INCR);
    set_burst(1, 1, 32'h0000_1100, 8'd3, 3'd2, BURST_INCR);
    set_burst(1, 2, 32'h0000_1238, 8'd3, 3'd2, BURST_INCR);
    set_burst(1, 3, 32'h0000_1210, 8'd2, 3'd1, BURST_FIXED);
    for (i = N_DIRECTED; i < N_BURSTS; i++) begin
      random_burst(0, i);
      random_burst(1, i);
    end

    repeat (2) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    fork
      drive_bursts(0);
      drive_bursts(1);
      drive_wdata();
    join

    cnt = 0;
    while (!drained()) begin
      @(posedge clk_i);
      #1;
      cnt++;
      if (cnt > TIMEOUT) begin
        fail_now("Timeout waiting for outstanding responses to drain");
      end
    end

    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- burst_splitter_top.sv
// Burst splitter top level with both address paths, W feed-through and responses
`timescale 1ns/1ps
`default_nettype none

module burst_splitter_top (
  input  wire                                   clk_i,
  input  wire                                   arst_n_i,
  // Upstream write address
  input  burst_split_pkg::addr_t                s_aw_addr_i,
  input  burst_split_pkg::len_t                 s_aw_len_i,
  input  burst_split_pkg::size_t                s_aw_size_i,
  input  burst_split_pkg::burst_e               s_aw_burst_i,
  input  wire                                   s_aw_valid_i,
  output logic                                  s_aw_ready_o,
  // Upstream write data
  input  burst_split_pkg::data_t                s_w_data_i,
  input  wire [burst_split_pkg::DATA_W/8-1:0]   s_w_strb_i,
  input  wire                                   s_w_last_i,
  input  wire                                   s_w_valid_i,
  output logic                                  s_w_ready_o,
  // Upstream write response
  output burst_split_pkg::resp_e                s_b_resp_o,
  output logic                                  s_b_valid_o,
  input  wire                                   s_b_ready_i,
  // Upstream read address
  input  burst_split_pkg::addr_t                s_ar_addr_i,
  input  burst_split_pkg::len_t                 s_ar_len_i,
  input  burst_split_pkg::size_t                s_ar_size_i,
  input  burst_split_pkg::burst_e               s_ar_burst_i,
  input  wire                                   s_ar_valid_i,
  output logic                                  s_ar_ready_o,
  // Upstream read data
  output burst_split_pkg::data_t                s_r_data_o,
  output burst_split_pkg::resp_e                s_r_resp_o,
  output logic                                  s_r_last_o,
  output logic                                  s_r_valid_o,
  input  wire                                   s_r_ready_i,
  // Downstream write address
  output burst_split_pkg::addr_t                m_aw_addr_o,
  output burst_split_pkg::len_t                 m_aw_len_o,
  output burst_split_pkg::size_t                m_aw_size_o,
  output burst_split_pkg::burst_e               m_aw_burst_o,
  output logic                                  m_aw_valid_o,
  input  wire                                   m_aw_ready_i,
  // Downstream write data
  output burst_split_pkg::data_t                m_w_data_o,
  output logic [burst_split_pkg::DATA_W/8-1:0]  m_w_strb_o,
  output logic                                  m_w_last_o,
  output logic                                  m_w_valid_o,
  input  wire                                   m_w_ready_i,
  // Downstream write response
  input  burst_split_pkg::resp_e                m_b_resp_i,
  input  wire                                   m_b_valid_i,
  output logic                                  m_b_ready_o,
  // Downstream read address
  output burst_split_pkg::addr_t                m_ar_addr_o,
  output burst_split_pkg::len_t                 m_ar_len_o,
  output burst_split_pkg::size_t                m_ar_size_o,
  output burst_split_pkg::burst_e               m_ar_burst_o,
  output logic                                  m_ar_valid_o,
  input  wire                                   m_ar_ready_i,
  // Downstream read data
  input  burst_split_pkg::data_t                m_r_data_i,
  input  burst_split_pkg::resp_e                m_r_resp_i,
  input  wire                                   m_r_valid_i,
  output logic                                  m_r_ready_o
);
  import burst_split_pkg::*;

  logic aw_push, aw_full, aw_head_valid, b_pop;
  len_t aw_len, aw_head_len;
  logic ar_push, ar_full, ar_head_valid, r_pop;
  len_t ar_len, ar_head_len;

  // Downstream only ever sees single beats
  assign m_aw_len_o = '0;
  assign m_ar_len_o = '0;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------
  ax_splitter u_aw_splitter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ax_addr_i   (s_aw_addr_i),
    .ax_len_i    (s_aw_len_i),
    .ax_size_i   (s_aw_size_i),
    .ax_burst_i  (s_aw_burst_i),
    .ax_valid_i  (s_aw_valid_i),
    .ax_ready_o  (s_aw_ready_o),
    .ax_addr_o   (m_aw_addr_o),
    .ax_size_o   (m_aw_size_o),
    .ax_burst_o  (m_aw_burst_o),
    .ax_valid_o  (m_aw_valid_o),
    .ax_ready_i  (m_aw_ready_i),
    .fifo_full_i (aw_full),
    .len_push_o  (aw_push),
    .len_o       (aw_len)
  );

  burst_len_fifo u_aw_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (aw_push),
    .push_len_i   (aw_len),
    .pop_i        (b_pop),
    .full_o       (aw_full),
    .head_valid_o (aw_head_valid),
    .head_len_o   (aw_head_len)
  );

  // W passes through with last set on every beat
  assign m_w_data_o  = s_w_data_i;
  assign m_w_strb_o  = s_w_strb_i;
  assign m_w_last_o  = 1'b1;
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  b_merge u_b_merge (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .m_b_resp_i   (m_b_resp_i),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .s_b_resp_o   (s_b_resp_o),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .head_valid_i (aw_head_valid),
    .head_len_i   (aw_head_len),
    .pop_o        (b_pop)
  );

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------
  ax_splitter u_ar_splitter (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .ax_addr_i   (s_ar_addr_i),
    .ax_len_i    (s_ar_len_i),
    .ax_size_i   (s_ar_size_i),
    .ax_burst_i  (s_ar_burst_i),
    .ax_valid_i  (s_ar_valid_i),
    .ax_ready_o  (s_ar_ready_o),
    .ax_addr_o   (m_ar_addr_o),
    .ax_size_o   (m_ar_size_o),
    .ax_burst_o  (m_ar_burst_o),
    .ax_valid_o  (m_ar_valid_o),
    .ax_ready_i  (m_ar_ready_i),
    .fifo_full_i (ar_full),
    .len_push_o  (ar_push),
    .len_o       (ar_len)
  );

  burst_len_fifo u_ar_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (ar_push),
    .push_len_i   (ar_len),
    .pop_i        (r_pop),
    .full_o       (ar_full),
    .head_valid_o (ar_head_valid),
    .head_len_o   (ar_head_len)
  );

  // Data and response bypass the beat counter
  assign s_r_data_o = m_r_data_i;
  assign s_r_resp_o = m_r_resp_i;

  r_last_gen u_r_last_gen (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_last_o   (s_r_last_o),
    .head_valid_i (ar_head_valid),
    .head_len_i   (ar_head_len),
    .pop_o        (r_pop)
  );

endmodule

`default_nettype wire

//--- r_last_gen.sv
// Read beat counter that rebuilds the last flag of each burst
`timescale 1ns/1ps
`default_nettype none

module r_last_gen (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  input  wire                   m_r_valid_i,
  output logic                  m_r_ready_o,
  output logic                  s_r_valid_o,
  input  wire                   s_r_ready_i,
  output logic                  s_r_last_o,
  // Head of the read length queue
  input  wire                   head_valid_i,
  input  burst_split_pkg::len_t head_len_i,
  output logic                  pop_o
);
  import burst_split_pkg::*;

  len_t beat_cnt_q;
  logic beat_taken;

  assign s_r_valid_o = m_r_valid_i & head_valid_i;
  assign m_r_ready_o = s_r_ready_i & head_valid_i;
  assign s_r_last_o  = (beat_cnt_q == head_len_i);
  assign beat_taken  = s_r_valid_o & s_r_ready_i;
  assign pop_o       = beat_taken & s_r_last_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
    end else if (beat_taken) begin
      beat_cnt_q <= s_r_last_o ? '0 : beat_cnt_q + 1'b1;
    end
  end

  // Read data must belong to a burst already recorded
  a_no_orphan_r: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_r_valid_i |-> head_valid_i)
    else $error("Read beat without an outstanding burst");

endmodule

`default_nettype wire

//--- b_merge.sv
// Write response combiner that folds the beats of one burst into one B
`timescale 1ns/1ps
`default_nettype none

module b_merge (
  input  wire                    clk_i,
  input  wire                    arst_n_i,
  // Downstream single-beat responses
  input  burst_split_pkg::resp_e m_b_resp_i,
  input  wire                    m_b_valid_i,
  output logic                   m_b_ready_o,
  // Upstream burst response
  output burst_split_pkg::resp_e s_b_resp_o,
  output logic                   s_b_valid_o,
  input  wire                    s_b_ready_i,
  // Head of the write length queue
  input  wire                    head_valid_i,
  input  burst_split_pkg::len_t  head_len_i,
  output logic                   pop_o
);
  import burst_split_pkg::*;

  len_t beat_cnt_q;
  logic err_q;
  logic is_final;
  logic err_any;
  logic beat_taken;

  assign is_final   = (beat_cnt_q == head_len_i);
  // Sticky error over all beats seen so far, this one included
  assign err_any    = err_q | m_b_resp_i[1];
  assign beat_taken = m_b_valid_i & m_b_ready_o;

  always_comb begin
    m_b_ready_o = 1'b0;
    s_b_valid_o = 1'b0;
    pop_o       = 1'b0;
    s_b_resp_o  = err_any ? RESP_SLVERR : m_b_resp_i;
    if (m_b_valid_i && head_valid_i) begin
      if (is_final) begin
        // Last beat waits for the upstream handshake
        s_b_valid_o = 1'b1;
        m_b_ready_o = s_b_ready_i;
        pop_o       = s_b_ready_i;
      end else begin
        m_b_ready_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
    end else if (beat_taken) begin
      if (is_final) begin
        beat_cnt_q <= '0;
        err_q      <= 1'b0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
        err_q      <= err_any;
      end
    end
  end

  // A write response needs an address accepted before it
  a_no_orphan_b: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    m_b_valid_i |-> head_valid_i)
    else $error("Write response without an outstanding burst");

endmodule

`default_nettype wire

//--- burst_len_fifo.sv
// In-order queue of outstanding burst lengths for one direction
`timescale 1ns/1ps
`default_nettype none

module burst_len_fifo (
  input  wire                   clk_i,
  input  wire                   arst_n_i,
  input  wire                   push_i,
  input  burst_split_pkg::len_t push_len_i,
  input  wire                   pop_i,
  output logic                  full_o,
  output logic                  head_valid_o,
  output burst_split_pkg::len_t head_len_o
);
  import burst_split_pkg::*;

  typedef logic [CNT_W-2:0] ptr_t;

  len_t             mem [MAX_TXNS];
  ptr_t             wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  // Circular increment that also works for non power of two depths
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(MAX_TXNS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o       = (count_q == CNT_W'(MAX_TXNS));
  assign head_valid_o = (count_q != '0);
  assign head_len_o   = mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_len_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o)
    else $error("Burst length pushed into a full queue");

  a_no_underflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> head_valid_o)
    else $error("Burst length popped from an empty queue");

endmodule

`default_nettype wire

//--- ax_splitter.sv
// Address channel splitter that issues one burst as single-beat requests
`timescale 1ns/1ps
`default_nettype none

module ax_splitter (
  input  wire                     clk_i,
  input  wire                     arst_n_i,
  // Upstream address channel
  input  burst_split_pkg::addr_t  ax_addr_i,
  input  burst_split_pkg::len_t   ax_len_i,
  input  burst_split_pkg::size_t  ax_size_i,
  input  burst_split_pkg::burst_e ax_burst_i,
  input  wire                     ax_valid_i,
  output logic                    ax_ready_o,
  // Downstream single-beat requests
  output burst_split_pkg::addr_t  ax_addr_o,
  output burst_split_pkg::size_t  ax_size_o,
  output burst_split_pkg::burst_e ax_burst_o,
  output logic                    ax_valid_o,
  input  wire                     ax_ready_i,
  // Burst length record
  input  wire                     fifo_full_i,
  output logic                    len_push_o,
  output burst_split_pkg::len_t   len_o
);
  import burst_split_pkg::*;

  split_state_e state_q, state_d;
  addr_t        addr_q, addr_d;
  len_t         len_q, len_d;
  size_t        size_q, size_d;
  burst_e       burst_q, burst_d;

  // Address of the following beat, FIXED keeps it unchanged
  function automatic addr_t next_addr(addr_t addr, size_t size, burst_e burst);
    if (burst == BURST_INCR) begin
      return addr + (addr_t'(1) << size);
    end
    return addr;
  endfunction

  assign len_o = ax_len_i;

  // --------------------------------------------------
  // Request sequencing
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    addr_d     = addr_q;
    len_d      = len_q;
    size_d     = size_q;
    burst_d    = burst_q;
    ax_ready_o = 1'b0;
    ax_valid_o = 1'b0;
    len_push_o = 1'b0;
    ax_addr_o  = ax_addr_i;
    ax_size_o  = ax_size_i;
    ax_burst_o = ax_burst_i;

    case (state_q)
      SPLIT_IDLE: begin
        if (ax_valid_i && !fifo_full_i) begin
          ax_valid_o = 1'b1;
          if (ax_len_i == '0) begin
            // Single beat goes straight through
            ax_ready_o = ax_ready_i;
            len_push_o = ax_ready_i;
          end else begin
            // Take the whole burst now and offer its first beat
            ax_ready_o = 1'b1;
            len_push_o = 1'b1;
            size_d     = ax_size_i;
            burst_d    = ax_burst_i;
            state_d    = SPLIT_BUSY;
            if (ax_ready_i) begin
              len_d  = ax_len_i - 1'b1;
              addr_d = next_addr(ax_addr_i, ax_size_i, ax_burst_i);
            end else begin
              len_d  = ax_len_i;
              addr_d = ax_addr_i;
            end
          end
        end
      end
      SPLIT_BUSY: begin
        ax_valid_o = 1'b1;
        ax_addr_o  = addr_q;
        ax_size_o  = size_q;
        ax_burst_o = burst_q;
        if (ax_ready_i) begin
          if (len_q == '0) begin
            state_d = SPLIT_IDLE;
          end else begin
            len_d  = len_q - 1'b1;
            addr_d = next_addr(addr_q, size_q, burst_q);
          end
        end
      end
      default: state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Latched request, only meaningful while busy
  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    len_q   <= len_d;
    size_q  <= size_d;
    burst_q <= burst_d;
  end

  // Wrapping bursts cannot be rebuilt from independent beats
  a_no_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ax_valid_i && ax_ready_o) |-> (ax_burst_i != BURST_WRAP))
    else $error("WRAP burst accepted by splitter");

  // Downstream request stays put until it is taken
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ax_valid_o && !ax_ready_i) |=> (ax_valid_o && $stable(ax_addr_o)))
    else $error("Downstream request dropped before ready");

endmodule

`default_nettype wire

//--- burst_split_pkg.sv
// Burst splitter package with bus widths, queue depth and shared enums
`default_nettype none

package burst_split_pkg;

  // --------------------------------------------------
  // Widths and depth
  // --------------------------------------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int LEN_W    = 8;
  localparam int SIZE_W   = 3;
  // Outstanding bursts per direction
  localparam int MAX_TXNS = 4;
  localparam int CNT_W    = $clog2(MAX_TXNS) + 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [SIZE_W-1:0] size_t;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Bit 1 set means an error response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_BUSY
  } split_state_e;

endpackage

`default_nettype wire
